/* src/id_pkg.sv */
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [11:0] alu_op_t;   // one-hot, bit 0 add up to bit 11 lui
    typedef logic [4:0]  exccode_t;
    typedef logic [1:0]  src2_sel_t;
    typedef logic [2:0]  br_kind_t;

    localparam exccode_t EXC_SYS = 5'd8;
    localparam exccode_t EXC_BP  = 5'd9;
    localparam exccode_t EXC_RI  = 5'd10;

    localparam src2_sel_t SRC2_REG  = 2'd0;
    localparam src2_sel_t SRC2_ZEXT = 2'd1;
    localparam src2_sel_t SRC2_SEXT = 2'd2;

    localparam br_kind_t BR_NONE = 3'd0;
    localparam br_kind_t BR_EQ   = 3'd1;
    localparam br_kind_t BR_NE   = 3'd2;
    localparam br_kind_t BR_GEZ  = 3'd3;
    localparam br_kind_t BR_LTZ  = 3'd4;
    localparam br_kind_t BR_JUMP = 3'd5;   // j and jal
    localparam br_kind_t BR_REG  = 3'd6;   // jr

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_SRA     = 6'h03;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_BREAK   = 6'h0d;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_NOR     = 6'h27;
    localparam logic [5:0] FN_SLT     = 6'h2a;
    localparam logic [5:0] FN_SLTU    = 6'h2b;

    // rt field of REGIMM
    localparam reg_addr_t RT_BLTZ = 5'd0;
    localparam reg_addr_t RT_BGEZ = 5'd1;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        reg_addr_t dest;     // 0 when the stage writes nothing
        word_t     result;
    } fwd_src_t;

    typedef struct packed {
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dest;
        imm_t        imm;
        alu_op_t     alu_op;
        logic        load_op;
        logic        mem_we;
        logic        gr_we;
        logic        src1_is_sa;
        logic        src1_is_pc;
        src2_sel_t   src2_sel;
        logic        src2_is_8;
        logic        uses_rs;
        logic        uses_rt;
        br_kind_t    br_kind;
        logic [25:0] jidx_low;
    } id_ctrl_t;

    typedef struct packed {
        logic  stall;
        logic  taken;
        word_t target;
    } br_bus_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      load_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        src2_sel_t src2_sel;
        logic      src2_is_8;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        imm_t      imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
        logic      ex;
        exccode_t  exccode;
    } ds_to_es_t;

endpackage

`default_nettype wire

/* src/id_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_pipe_reg (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              in_valid,
    input  id_pkg::fs_to_ds_t in_bus,
    output logic              in_ready,
    input  logic              ready_go,
    input  logic              es_ready,
    output logic              ds_valid,
    output logic              out_valid,
    output id_pkg::fs_to_ds_t ds_bus
);
    import id_pkg::*;

    logic valid_q;
    fs_to_ds_t bus_q;

    assign out_valid = valid_q && ready_go;        // held back during load-use
    assign in_ready  = !valid_q || (out_valid && es_ready);
    assign ds_valid  = valid_q;
    assign ds_bus    = bus_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            bus_q <= in_bus;
        end
    end

    // stage output must not move while EXE is stalling us
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !es_ready |=> $stable(ds_bus))
        else $error("decode bus changed under back-pressure");

endmodule

`default_nettype wire

/* src/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  id_pkg::word_t    inst,
    output id_pkg::id_ctrl_t ctrl,
    output logic             ex,
    output id_pkg::exccode_t exccode
);
    import id_pkg::*;

    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t sa;
    logic r_form;     // SPECIAL with sa zero
    logic s_form;     // SPECIAL with rs zero
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_syscall, inst_break;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_bgez, inst_bltz, inst_j, inst_jal;
    logic r_arith, shift, imm_sext, imm_zext, cond_br, defined;

    assign op = inst[31:26];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign sa = inst[10:6];
    assign fn = inst[5:0];

    assign r_form = (op == OP_SPECIAL) && (sa == '0);
    assign s_form = (op == OP_SPECIAL) && (rs == '0);

    assign inst_addu    = r_form && (fn == FN_ADDU);
    assign inst_subu    = r_form && (fn == FN_SUBU);
    assign inst_slt     = r_form && (fn == FN_SLT);
    assign inst_sltu    = r_form && (fn == FN_SLTU);
    assign inst_and     = r_form && (fn == FN_AND);
    assign inst_or      = r_form && (fn == FN_OR);
    assign inst_xor     = r_form && (fn == FN_XOR);
    assign inst_nor     = r_form && (fn == FN_NOR);
    assign inst_sll     = s_form && (fn == FN_SLL);
    assign inst_srl     = s_form && (fn == FN_SRL);
    assign inst_sra     = s_form && (fn == FN_SRA);
    assign inst_jr      = r_form && (fn == FN_JR) && (rt == '0) && (rd == '0);
    assign inst_syscall = (op == OP_SPECIAL) && (fn == FN_SYSCALL);   // code field ignored
    assign inst_break   = (op == OP_SPECIAL) && (fn == FN_BREAK);
    assign inst_addiu   = (op == OP_ADDIU);
    assign inst_slti    = (op == OP_SLTI);
    assign inst_sltiu   = (op == OP_SLTIU);
    assign inst_andi    = (op == OP_ANDI);
    assign inst_ori     = (op == OP_ORI);
    assign inst_xori    = (op == OP_XORI);
    assign inst_lui     = (op == OP_LUI) && (rs == '0);
    assign inst_lw      = (op == OP_LW);
    assign inst_sw      = (op == OP_SW);
    assign inst_beq     = (op == OP_BEQ);
    assign inst_bne     = (op == OP_BNE);
    assign inst_bgez    = (op == OP_REGIMM) && (rt == RT_BGEZ);
    assign inst_bltz    = (op == OP_REGIMM) && (rt == RT_BLTZ);
    assign inst_j       = (op == OP_J);
    assign inst_jal     = (op == OP_JAL);

    assign r_arith  = inst_addu | inst_subu | inst_slt | inst_sltu |
                      inst_and | inst_or | inst_xor | inst_nor;
    assign shift    = inst_sll | inst_srl | inst_sra;
    assign imm_sext = inst_addiu | inst_slti | inst_sltiu;
    assign imm_zext = inst_andi | inst_ori | inst_xori | inst_lui;
    assign cond_br  = inst_beq | inst_bne | inst_bgez | inst_bltz;
    assign defined  = r_arith | shift | imm_sext | imm_zext | cond_br | inst_lw | inst_sw |
                      inst_j | inst_jal | inst_jr | inst_syscall | inst_break;

    always_comb begin
        ctrl.rs       = rs;
        ctrl.rt       = rt;
        ctrl.imm      = inst[15:0];
        ctrl.jidx_low = inst[25:0];
        // bit order add, sub, slt, sltu, and, nor, or, xor, sll, srl, sra, lui
        ctrl.alu_op   = {inst_lui, inst_sra, inst_srl, inst_sll,
                         inst_xor | inst_xori, inst_or | inst_ori, inst_nor,
                         inst_and | inst_andi, inst_sltu | inst_sltiu, inst_slt | inst_slti,
                         inst_subu, inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal};
        ctrl.load_op    = inst_lw;
        ctrl.mem_we     = inst_sw;
        ctrl.gr_we      = r_arith | shift | imm_sext | imm_zext | inst_lw | inst_jal;
        ctrl.src1_is_sa = shift;
        ctrl.src1_is_pc = inst_jal;                // link value is pc + 8
        ctrl.src2_is_8  = inst_jal;
        ctrl.uses_rs    = r_arith | imm_sext | (imm_zext & !inst_lui) | inst_lw | inst_sw |
                          cond_br | inst_jr;
        ctrl.uses_rt    = r_arith | shift | inst_sw | inst_beq | inst_bne;

        if (imm_zext)                        ctrl.src2_sel = SRC2_ZEXT;
        else if (imm_sext | inst_lw | inst_sw) ctrl.src2_sel = SRC2_SEXT;
        else                                 ctrl.src2_sel = SRC2_REG;

        if (inst_jal)                                 ctrl.dest = 5'd31;
        else if (imm_sext | imm_zext | inst_lw)       ctrl.dest = rt;
        else if (inst_sw | cond_br | inst_j | inst_jr) ctrl.dest = '0;
        else                                          ctrl.dest = rd;

        if (inst_beq)               ctrl.br_kind = BR_EQ;
        else if (inst_bne)          ctrl.br_kind = BR_NE;
        else if (inst_bgez)         ctrl.br_kind = BR_GEZ;
        else if (inst_bltz)         ctrl.br_kind = BR_LTZ;
        else if (inst_j | inst_jal) ctrl.br_kind = BR_JUMP;
        else if (inst_jr)           ctrl.br_kind = BR_REG;
        else                        ctrl.br_kind = BR_NONE;
    end

    assign ex = !defined | inst_syscall | inst_break;

    always_comb begin
        if (!defined)          exccode = EXC_RI;
        else if (inst_syscall) exccode = EXC_SYS;
        else if (inst_break)   exccode = EXC_BP;
        else                   exccode = '0;
    end

    alu_onehot: assert final ($onehot0(ctrl.alu_op))
        else $error("alu_op has more than one bit set");

endmodule

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              reset,
    input  id_pkg::reg_addr_t raddr1,
    output id_pkg::word_t     rdata1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata2,
    input  id_pkg::rf_write_t wr
);
    import id_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // no write-through, WB forwarding covers same-cycle writes
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* src/operand_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  logic             ds_valid,
    input  id_pkg::id_ctrl_t ctrl,
    input  id_pkg::word_t    rf_rdata1,
    input  id_pkg::word_t    rf_rdata2,
    input  id_pkg::fwd_src_t exe_fwd,
    input  id_pkg::fwd_src_t mem_fwd,
    input  id_pkg::fwd_src_t wb_fwd,
    input  logic             exe_is_load,
    output id_pkg::word_t    rs_value,
    output id_pkg::word_t    rt_value,
    output logic             load_stall
);
    import id_pkg::*;

    logic rs_exe_hit;
    logic rt_exe_hit;

    // youngest producer wins
    function automatic word_t pick(input logic used, input reg_addr_t src,
                                   input word_t rf_value, input fwd_src_t exe,
                                   input fwd_src_t mem, input fwd_src_t wb);
        if (!used || (src == '0)) return rf_value;
        if (src == exe.dest)      return exe.result;
        if (src == mem.dest)      return mem.result;
        if (src == wb.dest)       return wb.result;
        return rf_value;
    endfunction

    assign rs_value = pick(ctrl.uses_rs, ctrl.rs, rf_rdata1, exe_fwd, mem_fwd, wb_fwd);
    assign rt_value = pick(ctrl.uses_rt, ctrl.rt, rf_rdata2, exe_fwd, mem_fwd, wb_fwd);

    assign rs_exe_hit = ctrl.uses_rs && (ctrl.rs != '0) && (ctrl.rs == exe_fwd.dest);
    assign rt_exe_hit = ctrl.uses_rt && (ctrl.rt != '0) && (ctrl.rt == exe_fwd.dest);

    // load data not ready until MEM
    assign load_stall = ds_valid && exe_is_load && (rs_exe_hit || rt_exe_hit);

    no_idle_stall: assert final (ds_valid || !load_stall)
        else $error("load-use stall without a valid instruction");

endmodule

`default_nettype wire

/* src/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic             ds_valid,
    input  id_pkg::word_t    pc,
    input  id_pkg::id_ctrl_t ctrl,
    input  id_pkg::word_t    rs_value,
    input  id_pkg::word_t    rt_value,
    input  logic             load_stall,
    output id_pkg::br_bus_t  br_bus
);
    import id_pkg::*;

    logic cond;
    word_t br_offset;

    assign br_offset = {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00};

    always_comb begin
        case (ctrl.br_kind)
            BR_EQ:           cond = (rs_value == rt_value);
            BR_NE:           cond = (rs_value != rt_value);
            BR_GEZ:          cond = !rs_value[31];
            BR_LTZ:          cond = rs_value[31];
            BR_JUMP, BR_REG: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    always_comb begin
        br_bus.taken = ds_valid && cond;
        br_bus.stall = br_bus.taken && load_stall;   // fetch waits for real operands
        case (ctrl.br_kind)
            BR_JUMP: br_bus.target = {pc[31:28], ctrl.jidx_low, 2'b00};
            BR_REG:  br_bus.target = rs_value;
            default: br_bus.target = pc + br_offset;
        endcase
    end

endmodule

`default_nettype wire

/* src/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              in_valid,
    input  id_pkg::fs_to_ds_t in_bus,
    output logic              in_ready,
    output logic              out_valid,
    output id_pkg::ds_to_es_t out_bus,
    input  logic              es_ready,
    input  id_pkg::rf_write_t wb_write,
    input  id_pkg::fwd_src_t  exe_fwd,
    input  id_pkg::fwd_src_t  mem_fwd,
    input  id_pkg::fwd_src_t  wb_fwd,
    input  logic              exe_is_load,
    output id_pkg::br_bus_t   br_bus
);
    import id_pkg::*;

    logic      ds_valid;
    logic      load_stall;
    fs_to_ds_t ds_bus;
    id_ctrl_t  ctrl;
    logic      dec_ex;
    exccode_t  dec_exccode;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rs_value;
    word_t     rt_value;

    id_pipe_reg u_pipe_reg (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_bus    (in_bus),
        .in_ready  (in_ready),
        .ready_go  (!load_stall),
        .es_ready  (es_ready),
        .ds_valid  (ds_valid),
        .out_valid (out_valid),
        .ds_bus    (ds_bus)
    );

    inst_decoder u_decoder (
        .inst    (ds_bus.inst),
        .ctrl    (ctrl),
        .ex      (dec_ex),
        .exccode (dec_exccode)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (ctrl.rs),
        .rdata1 (rf_rdata1),
        .raddr2 (ctrl.rt),
        .rdata2 (rf_rdata2),
        .wr     (wb_write)
    );

    operand_bypass u_bypass (
        .ds_valid    (ds_valid),
        .ctrl        (ctrl),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .exe_is_load (exe_is_load),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .load_stall  (load_stall)
    );

    branch_unit u_branch (
        .ds_valid   (ds_valid),
        .pc         (ds_bus.pc),
        .ctrl       (ctrl),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall),
        .br_bus     (br_bus)
    );

    always_comb begin
        out_bus.alu_op     = ctrl.alu_op;
        out_bus.load_op    = ctrl.load_op;
        out_bus.src1_is_sa = ctrl.src1_is_sa;
        out_bus.src1_is_pc = ctrl.src1_is_pc;
        out_bus.src2_sel   = ctrl.src2_sel;
        out_bus.src2_is_8  = ctrl.src2_is_8;
        out_bus.gr_we      = ctrl.gr_we;
        out_bus.mem_we     = ctrl.mem_we;
        out_bus.dest       = ctrl.dest;
        out_bus.imm        = ctrl.imm;
        out_bus.rs_value   = rs_value;
        out_bus.rt_value   = rt_value;
        out_bus.pc         = ds_bus.pc;
        out_bus.ex         = dec_ex;
        out_bus.exccode    = dec_exccode;
    end

endmodule

`default_nettype wire

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    localparam int N_INST      = 2000;
    localparam int CYCLE_LIMIT = 20 * N_INST;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // alu_op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef struct packed {
        ds_to_es_t bus;
        logic      uses_rs;
        logic      uses_rt;
        br_kind_t  br_kind;
    } ref_dec_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      flush;
    logic      in_valid;
    fs_to_ds_t in_bus;
    logic      in_ready;
    logic      out_valid;
    ds_to_es_t out_bus;
    logic      es_ready;
    rf_write_t wb_write;
    fwd_src_t  exe_fwd;
    fwd_src_t  mem_fwd;
    fwd_src_t  wb_fwd;
    logic      exe_is_load;
    br_bus_t   br_bus;

    logic [31:0] lfsr = 32'h024f_6077;
    word_t       shadow [32];
    fs_to_ds_t   held_q [$];     // accepted, not yet passed to EXE
    logic        accept_now;
    logic        pop_now;
    logic        fwd_held;
    logic        bp_prev = 1'b0;
    logic        flush_prev = 1'b0;
    ds_to_es_t   bus_prev;
    int          errors = 0;
    int          checks = 0;
    int          accepted = 0;
    int          cycles = 0;

    always #4 clk = ~clk;

    id_stage u_dut (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .es_ready    (es_ready),
        .wb_write    (wb_write),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .exe_is_load (exe_is_load),
        .br_bus      (br_bus)
    );

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // kinds 0..28 are legal, the rest are raw words
    function automatic word_t make_inst(input logic [4:0] kind);
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        rs  = 5'(take_bits(3));   // r0..r7 so forwarding hits often
        rt  = 5'(take_bits(3));
        rd  = 5'(take_bits(3));
        imm = 16'(take_bits(16));
        case (kind)
            5'd0:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
            5'd1:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
            5'd2:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
            5'd3:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLTU};
            5'd4:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
            5'd5:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
            5'd6:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
            5'd7:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_NOR};
            5'd8:  return {OP_SPECIAL, 5'd0, rt, rd, imm[10:6], FN_SLL};
            5'd9:  return {OP_SPECIAL, 5'd0, rt, rd, imm[10:6], FN_SRL};
            5'd10: return {OP_SPECIAL, 5'd0, rt, rd, imm[10:6], FN_SRA};
            5'd11: return {OP_SPECIAL, rs, 15'd0, FN_JR};
            5'd12: return {OP_ADDIU, rs, rt, imm};
            5'd13: return {OP_SLTI, rs, rt, imm};
            5'd14: return {OP_SLTIU, rs, rt, imm};
            5'd15: return {OP_ANDI, rs, rt, imm};
            5'd16: return {OP_ORI, rs, rt, imm};
            5'd17: return {OP_XORI, rs, rt, imm};
            5'd18: return {OP_LUI, 5'd0, rt, imm};
            5'd19: return {OP_LW, rs, rt, imm};
            5'd20: return {OP_SW, rs, rt, imm};
            5'd21: return {OP_BEQ, rs, rt, imm};
            5'd22: return {OP_BNE, rs, rt, imm};
            5'd23: return {OP_REGIMM, rs, RT_BGEZ, imm};
            5'd24: return {OP_REGIMM, rs, RT_BLTZ, imm};
            5'd25: return {OP_J, 26'(take_bits(26))};
            5'd26: return {OP_JAL, 26'(take_bits(26))};
            5'd27: return {OP_SPECIAL, 20'(take_bits(20)), FN_SYSCALL};
            5'd28: return {OP_SPECIAL, 20'(take_bits(20)), FN_BREAK};
            default: return take_bits(32);
        endcase
    endfunction

    // reference decode table
    function automatic ref_dec_t decode_ref(input word_t inst);
        ref_dec_t   d;
        logic [5:0] op;
        logic [5:0] fn;
        logic       ok;
        int         alu;
        op  = inst[31:26];
        fn  = inst[5:0];
        d   = '0;
        d.bus.dest = inst[15:11];
        ok  = 1'b1;
        alu = -1;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADDU: alu = ALU_ADD;
                    FN_SUBU: alu = ALU_SUB;
                    FN_SLT:  alu = ALU_SLT;
                    FN_SLTU: alu = ALU_SLTU;
                    FN_AND:  alu = ALU_AND;
                    FN_NOR:  alu = ALU_NOR;
                    FN_OR:   alu = ALU_OR;
                    FN_XOR:  alu = ALU_XOR;
                    FN_SLL:  alu = ALU_SLL;
                    FN_SRL:  alu = ALU_SRL;
                    FN_SRA:  alu = ALU_SRA;
                    default: alu = -1;
                endcase
                if (fn == FN_SYSCALL) begin
                    d.bus.ex = 1'b1;
                    d.bus.exccode = EXC_SYS;
                end else if (fn == FN_BREAK) begin
                    d.bus.ex = 1'b1;
                    d.bus.exccode = EXC_BP;
                end else if (fn == FN_JR) begin
                    ok = (inst[20:6] == '0);
                    d.uses_rs = 1'b1;
                    d.br_kind = BR_REG;
                    d.bus.dest = '0;
                end else if (alu >= ALU_SLL) begin
                    ok = (inst[25:21] == '0);   // shifts need rs zero
                    d.bus.src1_is_sa = 1'b1;
                    d.uses_rt = 1'b1;
                    d.bus.gr_we = 1'b1;
                end else if (alu >= 0) begin
                    ok = (inst[10:6] == '0);
                    d.uses_rs = 1'b1;
                    d.uses_rt = 1'b1;
                    d.bus.gr_we = 1'b1;
                end else begin
                    ok = 1'b0;
                end
            end
            OP_REGIMM: begin
                ok = (inst[20:16] == RT_BGEZ) || (inst[20:16] == RT_BLTZ);
                d.uses_rs = 1'b1;
                d.br_kind = (inst[20:16] == RT_BGEZ) ? BR_GEZ : BR_LTZ;
                d.bus.dest = '0;
            end
            OP_J, OP_JAL: begin
                d.br_kind = BR_JUMP;
                d.bus.dest = '0;
                if (op == OP_JAL) begin
                    d.bus.dest = 5'd31;          // link register
                    d.bus.gr_we = 1'b1;
                    d.bus.src1_is_pc = 1'b1;
                    d.bus.src2_is_8 = 1'b1;
                    alu = ALU_ADD;
                end
            end
            OP_BEQ, OP_BNE: begin
                d.uses_rs = 1'b1;
                d.uses_rt = 1'b1;
                d.br_kind = (op == OP_BEQ) ? BR_EQ : BR_NE;
                d.bus.dest = '0;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW, OP_SW: begin
                d.bus.src2_sel = SRC2_SEXT;
                d.uses_rs = 1'b1;
                d.uses_rt = (op == OP_SW);   // store data
                d.bus.load_op = (op == OP_LW);
                d.bus.mem_we = (op == OP_SW);
                d.bus.gr_we = (op != OP_SW);
                d.bus.dest = (op == OP_SW) ? 5'd0 : inst[20:16];
                alu = (op == OP_SLTI) ? ALU_SLT : (op == OP_SLTIU) ? ALU_SLTU : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ok = (op != OP_LUI) || (inst[25:21] == '0);
                d.bus.src2_sel = SRC2_ZEXT;
                d.uses_rs = (op != OP_LUI);
                d.bus.gr_we = 1'b1;
                d.bus.dest = inst[20:16];
                alu = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR :
                      (op == OP_XORI) ? ALU_XOR : ALU_LUI;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            d = '0;
            d.bus.dest = inst[15:11];
            d.bus.ex = 1'b1;
            d.bus.exccode = EXC_RI;
        end else if (alu >= 0) begin
            d.bus.alu_op[alu] = 1'b1;
        end
        d.bus.imm = inst[15:0];
        return d;
    endfunction

    function automatic word_t operand_ref(input logic used, input reg_addr_t r);
        word_t v;
        v = shadow[r];
        if (used && r != 5'd0) begin
            // oldest first, younger stages overwrite
            if (r == wb_fwd.dest) v = wb_fwd.result;
            if (r == mem_fwd.dest) v = mem_fwd.result;
            if (r == exe_fwd.dest) v = exe_fwd.result;
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at time %0t: %s got %0h expected %0h",
                     $time, name, got, exp);
        end
    endtask

    task automatic drive_inputs();
        fwd_held       = (take_bits(2) == 0);
        in_valid       = (take_bits(2) != 0);
        in_bus.pc      = {30'(take_bits(30)), 2'b00};
        in_bus.inst    = make_inst(5'(take_bits(5)));
        es_ready       = (take_bits(2) != 0);
        flush          = (take_bits(5) == 0);
        wb_write.we    = 1'(take_bits(1));
        wb_write.addr  = 5'(take_bits(3));
        wb_write.data  = take_bits(32);
        if (!fwd_held) begin
            exe_fwd.dest   = 5'(take_bits(3));
            exe_fwd.result = take_bits(32);
            mem_fwd.dest   = 5'(take_bits(3));
            mem_fwd.result = take_bits(32);
            wb_fwd.dest    = 5'(take_bits(3));
            wb_fwd.result  = take_bits(32);
            exe_is_load    = (take_bits(2) == 0);
        end
    endtask

    task automatic check_outputs();
        ref_dec_t  d;
        fs_to_ds_t held;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     rs_exp;
        word_t     rt_exp;
        word_t     target_exp;
        logic      have;
        logic      cond;
        logic      stall_exp;
        logic      taken_exp;
        logic      ovalid_exp;
        logic      iready_exp;
        have = (held_q.size() != 0);
        held = have ? held_q[0] : '0;
        d = decode_ref(held.inst);
        rs = held.inst[25:21];
        rt = held.inst[20:16];
        rs_exp = operand_ref(d.uses_rs, rs);
        rt_exp = operand_ref(d.uses_rt, rt);
        stall_exp = have && exe_is_load &&
                    ((d.uses_rs && rs != 0 && rs == exe_fwd.dest) ||
                     (d.uses_rt && rt != 0 && rt == exe_fwd.dest));
        case (d.br_kind)
            BR_EQ:           cond = (rs_exp == rt_exp);
            BR_NE:           cond = (rs_exp != rt_exp);
            BR_GEZ:          cond = !rs_exp[31];
            BR_LTZ:          cond = rs_exp[31];
            BR_JUMP, BR_REG: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
        taken_exp = have && cond;
        if (d.br_kind == BR_JUMP)
            target_exp = {held.pc[31:28], held.inst[25:0], 2'b00};
        else if (d.br_kind == BR_REG)
            target_exp = rs_exp;
        else
            target_exp = held.pc + {{14{held.inst[15]}}, held.inst[15:0], 2'b00};
        ovalid_exp = have && !stall_exp;
        iready_exp = !have || (ovalid_exp && es_ready);

        check_value("out_valid", out_valid, ovalid_exp);
        check_value("in_ready", in_ready, iready_exp);
        check_value("br_bus.taken", br_bus.taken, taken_exp);
        check_value("br_bus.stall", br_bus.stall, taken_exp && stall_exp);
        if (taken_exp) check_value("br_bus.target", br_bus.target, target_exp);
        if (flush_prev) check_value("out_valid", out_valid, 1'b0);   // flushed last edge

        if (ovalid_exp && es_ready) begin
            check_value("out_bus.alu_op", out_bus.alu_op, d.bus.alu_op);
            check_value("out_bus.load_op", out_bus.load_op, d.bus.load_op);
            check_value("out_bus.src1_is_sa", out_bus.src1_is_sa, d.bus.src1_is_sa);
            check_value("out_bus.src1_is_pc", out_bus.src1_is_pc, d.bus.src1_is_pc);
            check_value("out_bus.src2_sel", out_bus.src2_sel, d.bus.src2_sel);
            check_value("out_bus.src2_is_8", out_bus.src2_is_8, d.bus.src2_is_8);
            check_value("out_bus.gr_we", out_bus.gr_we, d.bus.gr_we);
            check_value("out_bus.mem_we", out_bus.mem_we, d.bus.mem_we);
            check_value("out_bus.dest", out_bus.dest, d.bus.dest);
            check_value("out_bus.imm", out_bus.imm, d.bus.imm);
            check_value("out_bus.pc", out_bus.pc, held.pc);
            check_value("out_bus.rs_value", out_bus.rs_value, rs_exp);
            check_value("out_bus.rt_value", out_bus.rt_value, rt_exp);
            check_value("out_bus.ex", out_bus.ex, d.bus.ex);
            check_value("out_bus.exccode", out_bus.exccode, d.bus.exccode);
        end

        // back-pressure with quiet forwarding inputs must leave the bus alone
        if (bp_prev && fwd_held) check_value("out_bus", out_bus, bus_prev);
        bp_prev = ovalid_exp && !es_ready && !flush && !wb_write.we;
        bus_prev = out_bus;
        flush_prev = flush;

        accept_now = in_valid && iready_exp;
        pop_now = ovalid_exp && es_ready;
        if (in_valid && in_ready) accepted++;
    endtask

    // model state after the clock edge
    task automatic update_model();
        if (wb_write.we && wb_write.addr != 5'd0) shadow[wb_write.addr] = wb_write.data;
        if (flush) begin
            held_q.delete();
        end else begin
            if (pop_now) void'(held_q.pop_front());
            if (accept_now) held_q.push_back(in_bus);
        end
    endtask

    initial begin
        int i;
        for (i = 0; i < 32; i++) shadow[i] = '0;
        reset       = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_bus      = '0;
        es_ready    = 1'b0;
        wb_write    = '0;
        exe_fwd     = '0;
        mem_fwd     = '0;
        wb_fwd      = '0;
        exe_is_load = 1'b0;
        fwd_held    = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (accepted < N_INST && cycles < CYCLE_LIMIT) begin
            drive_inputs();
            #2;                       // mid low phase, outputs settled
            check_outputs();
            @(posedge clk);
            update_model();
            @(negedge clk);
            cycles++;
        end

        if (accepted < N_INST) begin
            errors++;
            $display("timeout: only %0d of %0d instructions accepted in %0d cycles",
                     accepted, N_INST, cycles);
        end
        $display("accepted %0d, checks %0d, errors %0d", accepted, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/id_pkg.sv
src/id_pipe_reg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/branch_unit.sv
src/id_stage.sv
testbench/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - src/id_pkg.sv
  - src/id_pipe_reg.sv
  - src/inst_decoder.sv
  - src/regfile.sv
  - src/operand_bypass.sv
  - src/branch_unit.sv
  - src/id_stage.sv
  - target: test
    files:
      - testbench/tb_id_stage.sv
